// ==== hdl/arb_params.svh ====
`ifndef ARB_PARAMS_SVH
`define ARB_PARAMS_SVH

// number of requesters seen at the top
`define ARB_WIDTH 8

// requesters are split into this many equal groups
`define ARB_GROUP_NUM 4

// members in each group
`define ARB_GROUP_WIDTH (`ARB_WIDTH / `ARB_GROUP_NUM)

`endif

// ==== hdl/arb_pkg.sv ====
`include "arb_params.svh"

package arb_pkg;

    // request or grant over all requesters
    typedef logic [`ARB_WIDTH-1:0] req_vec_t;

    // one bit per group
    typedef logic [`ARB_GROUP_NUM-1:0] group_vec_t;

    // each output bit is set when any input bit at or below it is set,
    // so the lowest set bit turns into a rising edge of the code.
    // narrower vectors come in zero extended, upper result bits are ignored
    function automatic req_vec_t thermo(input req_vec_t in);
        req_vec_t code;
        logic     seen;
        code = '0;
        seen = 1'b0;
        for (int i = 0; i < `ARB_WIDTH; i++) begin
            seen    = seen | in[i];
            code[i] = seen;
        end
        return code;
    endfunction

endpackage

// ==== hdl/arb_thermo_if.sv ====
`timescale 1ns/1ns

interface arb_thermo_if #(
    parameter int WIDTH = 4
);

    // thermometer code of the raw request
    logic [WIDTH-1:0] req_thermo;

    // thermometer code after the priority mask
    logic [WIDTH-1:0] masked_thermo;

    // mask the pointer would take on an update this cycle
    logic [WIDTH-1:0] next_mask;

    modport decode (
        output req_thermo,
        output masked_thermo,
        input  next_mask
    );

    modport select (
        input  req_thermo,
        input  masked_thermo,
        output next_mask
    );

endinterface

// ==== hdl/rr_request_decode.sv ====
`timescale 1ns/1ns

module rr_request_decode #(
    parameter int WIDTH = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] request,
    input  logic             update_en,
    arb_thermo_if.decode     thermo
);

    // priority mask, a one marks a position that may win first
    logic [WIDTH-1:0] mask_q;
    logic [WIDTH-1:0] masked_request;

    // full-width copies for the package function
    arb_pkg::req_vec_t req_wide;
    arb_pkg::req_vec_t masked_wide;
    arb_pkg::req_vec_t req_code;
    arb_pkg::req_vec_t masked_code;

    // all ones after reset, so index 0 has top priority
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mask_q <= '1;
        end else if (update_en) begin
            mask_q <= thermo.next_mask;
        end
    end

    // requests still inside the round-robin window
    assign masked_request = request & mask_q;

    always_comb begin
        req_wide               = '0;
        masked_wide            = '0;
        req_wide[WIDTH-1:0]    = request;
        masked_wide[WIDTH-1:0] = masked_request;
    end

    assign req_code    = arb_pkg::thermo(req_wide);
    assign masked_code = arb_pkg::thermo(masked_wide);

    // only the low WIDTH bits carry this arbiter's code
    assign thermo.req_thermo    = req_code[WIDTH-1:0];
    assign thermo.masked_thermo = masked_code[WIDTH-1:0];

endmodule

// ==== hdl/rr_grant_select.sv ====
`timescale 1ns/1ns

module rr_grant_select #(
    parameter int WIDTH = 4
) (
    arb_thermo_if.select     thermo,
    output logic [WIDTH-1:0] grant
);

    logic             masked_hit;
    logic [WIDTH-1:0] win_code;
    logic [WIDTH-1:0] next_mask;

    // top bit of a thermometer code is the OR of the whole vector
    assign masked_hit = thermo.masked_thermo[WIDTH-1];

    // fall back to the raw request once the window is empty
    assign win_code = masked_hit ? thermo.masked_thermo : thermo.req_thermo;

    // every position strictly above the winner
    assign next_mask = {win_code[WIDTH-2:0], 1'b0};

    // only the edge of the code survives, which is one-hot or zero
    assign grant = win_code ^ next_mask;

    assign thermo.next_mask = next_mask;

endmodule

// ==== hdl/rr_arbiter_core.sv ====
`timescale 1ns/1ns

module rr_arbiter_core #(
    parameter int WIDTH = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [WIDTH-1:0] request,
    input  logic             update_en,
    output logic [WIDTH-1:0] grant,
    output logic             any_grant
);

    logic load_mask;

    arb_thermo_if #(
        .WIDTH (WIDTH)
    ) thermo_if ();

    assign any_grant = |request;

    // an idle cycle leaves the pointer where it is
    assign load_mask = update_en & any_grant;

    rr_request_decode #(
        .WIDTH (WIDTH)
    ) request_decode_inst (
        .clk       (clk),
        .reset     (reset),
        .request   (request),
        .update_en (load_mask),
        .thermo    (thermo_if.decode)
    );

    rr_grant_select #(
        .WIDTH (WIDTH)
    ) grant_select_inst (
        .thermo (thermo_if.select),
        .grant  (grant)
    );

endmodule

// ==== hdl/rr_tree_arbiter.sv ====
`timescale 1ns/1ns

`include "arb_params.svh"

module rr_tree_arbiter (
    input  logic              clk,
    input  logic              reset,
    input  arb_pkg::req_vec_t request,
    input  logic              priority_en,
    output arb_pkg::req_vec_t grant,
    output logic              any_grant
);

    // per-group slices of the request and the local winners
    logic [`ARB_GROUP_WIDTH-1:0] group_req   [`ARB_GROUP_NUM];
    logic [`ARB_GROUP_WIDTH-1:0] group_grant [`ARB_GROUP_NUM];

    // one bit per group
    arb_pkg::group_vec_t group_any_req;
    arb_pkg::group_vec_t group_win;
    arb_pkg::group_vec_t group_update;

    for (genvar g = 0; g < `ARB_GROUP_NUM; g++) begin : group_gen

        assign group_req[g] = request[g*`ARB_GROUP_WIDTH +: `ARB_GROUP_WIDTH];

        // a group pointer only moves when its group wins the second level
        assign group_update[g] = priority_en & group_win[g];

        rr_arbiter_core #(
            .WIDTH (`ARB_GROUP_WIDTH)
        ) group_arb_inst (
            .clk       (clk),
            .reset     (reset),
            .request   (group_req[g]),
            .update_en (group_update[g]),
            .grant     (group_grant[g]),
            .any_grant (group_any_req[g])
        );

        // losing groups keep their local choice off the output
        assign grant[g*`ARB_GROUP_WIDTH +: `ARB_GROUP_WIDTH] =
            group_win[g] ? group_grant[g] : '0;

    end

    // picks one group among those with a pending request
    // its any_grant is the OR of every request at the top
    rr_arbiter_core #(
        .WIDTH (`ARB_GROUP_NUM)
    ) group_level_arb_inst (
        .clk       (clk),
        .reset     (reset),
        .request   (group_any_req),
        .update_en (priority_en),
        .grant     (group_win),
        .any_grant (any_grant)
    );

endmodule

// ==== sim/arb_ref_model.svh ====
`ifndef ARB_REF_MODEL_SVH
`define ARB_REF_MODEL_SVH

// pointer state of the reference, one mask per group plus the group-level mask
logic [`ARB_GROUP_WIDTH-1:0] group_mask_ref [`ARB_GROUP_NUM];
logic [`ARB_GROUP_NUM-1:0]   top_mask_ref;

// lowest request inside the mask, else lowest request overall, -1 when idle
function automatic int rr_pick(
    input logic [`ARB_WIDTH-1:0] req,
    input logic [`ARB_WIDTH-1:0] mask,
    input int                    width
);
    int pick;
    pick = -1;
    for (int i = width - 1; i >= 0; i--) begin
        if (req[i]) begin
            pick = i;
        end
    end
    // a hit inside the mask overrides the plain lowest request
    for (int i = width - 1; i >= 0; i--) begin
        if (req[i] && mask[i]) begin
            pick = i;
        end
    end
    return pick;
endfunction

// all positions strictly above idx
function automatic logic [`ARB_WIDTH-1:0] mask_above(input int idx, input int width);
    logic [`ARB_WIDTH-1:0] m;
    m = '0;
    for (int i = 0; i < width; i++) begin
        m[i] = (i > idx);
    end
    return m;
endfunction

// winning group and its winning member, both -1 when nothing is requested
function automatic void find_winner(
    input  arb_pkg::req_vec_t req,
    output int                win_group,
    output int                win_member
);
    arb_pkg::group_vec_t busy;
    for (int g = 0; g < `ARB_GROUP_NUM; g++) begin
        busy[g] = |req[g*`ARB_GROUP_WIDTH +: `ARB_GROUP_WIDTH];
    end
    win_group  = rr_pick(busy, top_mask_ref, `ARB_GROUP_NUM);
    win_member = -1;
    if (win_group >= 0) begin
        win_member = rr_pick(req[win_group*`ARB_GROUP_WIDTH +: `ARB_GROUP_WIDTH],
                             group_mask_ref[win_group], `ARB_GROUP_WIDTH);
    end
endfunction

function automatic arb_pkg::req_vec_t predict_grant(input arb_pkg::req_vec_t req);
    arb_pkg::req_vec_t result;
    int                win_group;
    int                win_member;
    result = '0;
    find_winner(req, win_group, win_member);
    if (win_group >= 0) begin
        result[win_group*`ARB_GROUP_WIDTH + win_member] = 1'b1;
    end
    return result;
endfunction

// only the winning group moves at the coming rising edge
task automatic advance_pointers(input arb_pkg::req_vec_t req, input logic prio_en);
    int                    win_group;
    int                    win_member;
    logic [`ARB_WIDTH-1:0] next;
    find_winner(req, win_group, win_member);
    if (prio_en && win_group >= 0) begin
        next         = mask_above(win_group, `ARB_GROUP_NUM);
        top_mask_ref = next[`ARB_GROUP_NUM-1:0];
        next         = mask_above(win_member, `ARB_GROUP_WIDTH);
        group_mask_ref[win_group] = next[`ARB_GROUP_WIDTH-1:0];
    end
endtask

task automatic reset_pointers();
    for (int g = 0; g < `ARB_GROUP_NUM; g++) begin
        group_mask_ref[g] = '1;
    end
    top_mask_ref = '1;
endtask

`endif

// ==== sim/rr_tree_arbiter_tb.sv ====
`timescale 1ns/1ns

`include "arb_params.svh"

module rr_tree_arbiter_tb;

    localparam int CLK_PERIOD    = 8;
    localparam int GRANT_TIMEOUT = 16;
    localparam int RANDOM_CYCLES = 600;

    logic              clk;
    logic              reset;
    arb_pkg::req_vec_t request;
    logic              priority_en;
    arb_pkg::req_vec_t grant;
    logic              any_grant;

    integer seed;

    `include "arb_ref_model.svh"

    rr_tree_arbiter rr_tree_arbiter_inst (
        .clk         (clk),
        .reset       (reset),
        .request     (request),
        .priority_en (priority_en),
        .grant       (grant),
        .any_grant   (any_grant)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        assert (actual === expected) else begin
            abort_run($sformatf("[FAIL] time %0t ns: %s expected 'h%0h, actual 'h%0h",
                                $time, name, expected, actual));
        end
    endtask

    function automatic int lowest_index(input arb_pkg::req_vec_t req);
        int idx;
        idx = -1;
        for (int i = `ARB_WIDTH - 1; i >= 0; i--) begin
            if (req[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // shape of the grant and agreement with the reference
    task automatic check_outputs();
        arb_pkg::req_vec_t expected;
        expected = predict_grant(request);
        check_value("grant is one-hot or zero", 1, (grant & (grant - 1'b1)) == '0);
        check_value("grant is zero", request == '0, grant == '0);
        check_value("any_grant", |request, any_grant);
        check_value("grant & ~request", 0, grant & ~request);
        check_value("grant", expected, grant);
    endtask

    task automatic drive_inputs(input arb_pkg::req_vec_t req, input logic prio_en);
        @(posedge clk);
        request     <= req;
        priority_en <= prio_en;
    endtask

    // outputs are settled at the falling edge
    task automatic sample_cycle();
        @(negedge clk);
        check_outputs();
        advance_pointers(request, priority_en);
    endtask

    task automatic wait_for_grant(input int limit);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!any_grant && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!any_grant) begin
            abort_run($sformatf("no grant appeared within %0d cycles of a request", limit));
        end
        check_outputs();
        advance_pointers(request, priority_en);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset       <= 1'b1;
        request     <= '0;
        priority_en <= 1'b0;
        @(negedge clk);
        check_value("grant during reset", 0, grant);
        check_value("any_grant during reset", 0, any_grant);
        repeat (2) begin
            @(posedge clk);
        end
        reset <= 1'b0;
        reset_pointers();
    endtask

    // first grant after reset goes to the lowest active index
    task automatic check_reset_priority();
        arb_pkg::req_vec_t req;
        arb_pkg::req_vec_t expected;
        for (int n = 0; n < 6; n++) begin
            apply_reset();
            req = $random(seed) & $random(seed);
            if (req == '0) begin
                req[`ARB_WIDTH-1] = 1'b1;
            end
            drive_inputs(req, 1'b1);
            wait_for_grant(GRANT_TIMEOUT);
            expected = '0;
            expected[lowest_index(req)] = 1'b1;
            check_value("grant after reset", expected, grant);
        end
    endtask

    task automatic check_rotation();
        arb_pkg::req_vec_t expected;
        arb_pkg::req_vec_t visited;
        int                idx;
        apply_reset();
        visited = '0;
        for (int c = 0; c < 3 * `ARB_WIDTH; c++) begin
            drive_inputs('1, 1'b1);
            sample_cycle();
            // groups take turns, members step once per full turn of the groups
            idx = (c % `ARB_GROUP_NUM) * `ARB_GROUP_WIDTH
                + (c / `ARB_GROUP_NUM) % `ARB_GROUP_WIDTH;
            expected = '0;
            expected[idx] = 1'b1;
            check_value("grant in rotation", expected, grant);
            visited = visited | grant;
            if ((c + 1) % `ARB_WIDTH == 0) begin
                check_value("requesters granted in one round", {`ARB_WIDTH{1'b1}}, visited);
                visited = '0;
            end
        end
    endtask

    task automatic check_priority_hold();
        arb_pkg::req_vec_t req;
        arb_pkg::req_vec_t held;
        for (int n = 0; n < 8; n++) begin
            req = $random(seed);
            // one enabled cycle moves the pointers first
            drive_inputs(req, 1'b1);
            sample_cycle();
            held = predict_grant(req);
            for (int k = 0; k < 5; k++) begin
                drive_inputs(req, 1'b0);
                sample_cycle();
                check_value("grant with priority_en low", held, grant);
            end
        end
    endtask

    task automatic check_random_traffic();
        arb_pkg::req_vec_t req;
        logic [31:0]       r;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            req = $random(seed);
            r   = $random(seed);
            // sparse and idle cycles now and then
            if (r[2:1] == 2'b00) begin
                req = req & $random(seed);
            end
            if (r[6:3] == 4'b0000) begin
                req = '0;
            end
            drive_inputs(req, r[0]);
            sample_cycle();
        end
    endtask

    initial begin
        reset       = 1'b1;
        request     = '0;
        priority_en = 1'b0;
        seed        = 32'hb21;
        reset_pointers();
        repeat (2) begin
            @(posedge clk);
        end
        reset <= 1'b0;

        check_reset_priority();
        check_rotation();
        check_priority_hold();
        check_random_traffic();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+hdl
+incdir+sim
hdl/arb_pkg.sv
hdl/arb_thermo_if.sv
hdl/rr_request_decode.sv
hdl/rr_grant_select.sv
hdl/rr_arbiter_core.sv
hdl/rr_tree_arbiter.sv
sim/rr_tree_arbiter_tb.sv

// ==== Bender.yml ====
package:
  name: rr_tree_arbiter

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/arb_pkg.sv
      - hdl/arb_thermo_if.sv
      - hdl/rr_request_decode.sv
      - hdl/rr_grant_select.sv
      - hdl/rr_arbiter_core.sv
      - hdl/rr_tree_arbiter.sv

  - target: simulation
    include_dirs:
      - hdl
      - sim
    files:
      - sim/rr_tree_arbiter_tb.sv
